/* common/vec_pkg.sv */
package vec_pkg;

    // one-hot operation code, {dot, man, euc, avg, sum, read}
    localparam int op_width = 6;

    localparam int op_read_bit = 0;
    localparam int op_sum_bit  = 1;
    localparam int op_avg_bit  = 2;
    localparam int op_euc_bit  = 3;
    localparam int op_man_bit  = 4;
    localparam int op_dot_bit  = 5;

    // unsigned vector element
    localparam int elem_width = 8;

    // result word, sent over the serial line
    localparam int result_bytes = 4;
    localparam int result_width = 8 * result_bytes;

    // alu side writes the whole word
    // transmitter side picks one byte at a time, bytes[0] is the lsb
    typedef union packed {
        logic [result_width-1:0]     word;
        logic [result_bytes-1:0][7:0] bytes;
    } result_word_t;

endpackage

/* logic/vector_alu.sv */
`timescale 1ns/1ps

module vector_alu import vec_pkg::*; #(
    parameter int vec_len = 4
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           start,
    input  logic [op_width-1:0]            op,
    input  logic [vec_len*elem_width-1:0]  vec_a,
    input  logic [vec_len*elem_width-1:0]  vec_b,
    input  logic [$clog2(vec_len)-1:0]     rd_index,
    input  logic                           done,
    output result_word_t                   result,
    output logic                           op_done,
    output logic                           busy
);

    localparam int idx_width = $clog2(vec_len);

    typedef enum logic [1:0] {
        s_idle,
        s_accum,
        s_finish,
        s_hold
    } state_t;

    state_t state;

    logic [vec_len*elem_width-1:0] a_q;
    logic [vec_len*elem_width-1:0] b_q;
    logic [idx_width-1:0]          idx_q;
    logic [idx_width-1:0]          cnt;
    logic [result_width-1:0]       acc;

    logic [elem_width-1:0]   elem_a;
    logic [elem_width-1:0]   elem_b;
    logic [elem_width-1:0]   abs_diff;
    logic [elem_width-1:0]   read_elem;
    logic [2*elem_width-1:0] sq_diff;
    logic [2*elem_width-1:0] prod;
    logic [result_width-1:0] term;

    // element pair for the current step
    assign elem_a    = a_q[cnt*elem_width +: elem_width];
    assign elem_b    = b_q[cnt*elem_width +: elem_width];
    assign abs_diff  = (elem_a > elem_b) ? elem_a - elem_b : elem_b - elem_a;
    assign sq_diff   = abs_diff * abs_diff;
    assign prod      = elem_a * elem_b;
    assign read_elem = a_q[idx_q*elem_width +: elem_width];

    // what gets added this cycle
    always_comb begin
        term = '0;
        if (op[op_sum_bit] || op[op_avg_bit]) begin
            term = result_width'(elem_a);
        end else if (op[op_man_bit]) begin
            term = result_width'(abs_diff);
        end else if (op[op_euc_bit]) begin
            term = result_width'(sq_diff);
        end else if (op[op_dot_bit]) begin
            term = result_width'(prod);
        end
    end

    assign busy = (state != s_idle);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= s_idle;
            cnt     <= '0;
            op_done <= 1'b0;
        end else begin
            op_done <= 1'b0;
            case (state)
                s_idle: begin
                    if (start) begin
                        cnt   <= '0;
                        state <= s_accum;
                    end
                end
                // one element per cycle
                s_accum: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == idx_width'(vec_len - 1)) begin
                        state <= s_finish;
                    end
                end
                s_finish: begin
                    op_done <= 1'b1;
                    state   <= s_hold;
                end
                // result stays put until the transfer is over
                s_hold: begin
                    if (done) begin
                        state <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // operands and running sum
    always_ff @(posedge clk) begin
        if (state == s_idle && start) begin
            a_q   <= vec_a;
            b_q   <= vec_b;
            idx_q <= rd_index;
            acc   <= '0;
        end else if (state == s_accum) begin
            acc <= acc + term;
        end
    end

    // final result, avg is the floored mean
    always_ff @(posedge clk) begin
        if (state == s_finish) begin
            if (op[op_read_bit]) begin
                result.word <= result_width'(read_elem);
            end else if (op[op_avg_bit]) begin
                result.word <= acc / result_width'(vec_len);
            end else begin
                result.word <= acc;
            end
        end
    end

endmodule

/* tx_ctrl/tx_ctrl.sv */
`timescale 1ns/1ps

module tx_ctrl import vec_pkg::*; #(
    parameter int register_wait = 4
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                op_done,
    input  logic                tx_busy,
    input  logic [op_width-1:0] op,
    output logic                register_result,
    output logic                send_b0,
    output logic                send_b1,
    output logic                send_b2,
    output logic                send_b3,
    output logic                tx_start,
    output logic                done
);

    localparam int timer_width = $clog2(register_wait + 2);

    typedef enum logic [3:0] {
        s_idle,
        s_register,
        s_send_b0,
        s_wait_b0,
        s_send_b1,
        s_wait_b1,
        s_send_b2,
        s_wait_b2,
        s_send_b3,
        s_wait_b3,
        s_done
    } state_t;

    state_t state;
    state_t next_state;

    logic [timer_width-1:0] hold_timer;
    logic                   two_bytes;
    logic                   three_bytes;

    // byte count from the operation
    assign two_bytes   = op[op_read_bit] | op[op_sum_bit] | op[op_avg_bit];
    assign three_bytes = op[op_man_bit];

    always_comb begin
        next_state      = state;
        register_result = 1'b0;
        send_b0         = 1'b0;
        send_b1         = 1'b0;
        send_b2         = 1'b0;
        send_b3         = 1'b0;
        tx_start        = 1'b0;
        done            = 1'b0;

        case (state)
            s_idle: begin
                if (op_done) begin
                    next_state = s_register;
                end
            end
            s_register: begin
                register_result = 1'b1;
                if (hold_timer >= timer_width'(register_wait)) begin
                    next_state = s_send_b0;
                end
            end
            s_send_b0: begin
                send_b0    = 1'b1;
                tx_start   = 1'b1;
                next_state = s_wait_b0;
            end
            s_wait_b0: begin
                if (!tx_busy) begin
                    next_state = s_send_b1;
                end
            end
            s_send_b1: begin
                send_b1    = 1'b1;
                tx_start   = 1'b1;
                next_state = s_wait_b1;
            end
            // every op sends at least two bytes
            s_wait_b1: begin
                if (!tx_busy) begin
                    next_state = two_bytes ? s_done : s_send_b2;
                end
            end
            s_send_b2: begin
                send_b2    = 1'b1;
                tx_start   = 1'b1;
                next_state = s_wait_b2;
            end
            s_wait_b2: begin
                if (!tx_busy) begin
                    next_state = three_bytes ? s_done : s_send_b3;
                end
            end
            s_send_b3: begin
                send_b3    = 1'b1;
                tx_start   = 1'b1;
                next_state = s_wait_b3;
            end
            s_wait_b3: begin
                if (!tx_busy) begin
                    next_state = s_done;
                end
            end
            s_done: begin
                done       = 1'b1;
                next_state = s_idle;
            end
            default: next_state = s_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= s_idle;
        end else begin
            state <= next_state;
        end
    end

    // counts cycles spent in the register state
    always_ff @(posedge clk) begin
        if (reset || state != s_register) begin
            hold_timer <= '0;
        end else begin
            hold_timer <= hold_timer + 1'b1;
        end
    end

endmodule

/* uart/uart_result_tx.sv */
`timescale 1ns/1ps

module uart_result_tx import vec_pkg::*; #(
    parameter int clks_per_bit = 8
) (
    input  logic         clk,
    input  logic         reset,
    input  result_word_t result,
    input  logic         register_result,
    input  logic         send_b0,
    input  logic         send_b1,
    input  logic         send_b2,
    input  logic         send_b3,
    input  logic         tx_start,
    output logic         txd,
    output logic         tx_busy
);

    localparam int cnt_width  = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
    localparam int frame_bits = 10;

    result_word_t           result_q;
    logic [7:0]             sel_byte;
    logic [frame_bits-2:0]  frame;
    logic [cnt_width-1:0]   clk_cnt;
    logic [3:0]             bit_cnt;
    logic                   bit_end;

    // hold a copy of the result for the whole transfer
    always_ff @(posedge clk) begin
        if (register_result) begin
            result_q <= result;
        end
    end

    // byte picked by the one-hot send strobe
    always_comb begin
        case ({send_b3, send_b2, send_b1, send_b0})
            4'b0001: sel_byte = result_q.bytes[0];
            4'b0010: sel_byte = result_q.bytes[1];
            4'b0100: sel_byte = result_q.bytes[2];
            4'b1000: sel_byte = result_q.bytes[3];
            default: sel_byte = 8'h00;
        endcase
    end

    assign bit_end = (clk_cnt == cnt_width'(clks_per_bit - 1));

    // 8N1 frame: start bit, data lsb first, stop bit
    always_ff @(posedge clk) begin
        if (reset) begin
            tx_busy <= 1'b0;
            txd     <= 1'b1;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (!tx_busy) begin
            txd <= 1'b1;
            if (tx_start) begin
                tx_busy <= 1'b1;
                txd     <= 1'b0;
                clk_cnt <= '0;
                bit_cnt <= '0;
            end
        end else if (bit_end) begin
            clk_cnt <= '0;
            if (bit_cnt == 4'(frame_bits - 1)) begin
                // stop bit done
                tx_busy <= 1'b0;
                txd     <= 1'b1;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
                txd     <= frame[0];
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // data and stop bit, shifted right once per bit time
    always_ff @(posedge clk) begin
        if (!tx_busy && tx_start) begin
            frame <= {1'b1, sel_byte};
        end else if (tx_busy && bit_end) begin
            frame <= {1'b1, frame[frame_bits-2:1]};
        end
    end

endmodule

/* logic/vec_result_top.sv */
`timescale 1ns/1ps

module vec_result_top import vec_pkg::*; #(
    parameter int vec_len       = 4,
    parameter int register_wait = 4,
    parameter int clks_per_bit  = 8
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start,
    input  logic [op_width-1:0]           op,
    input  logic [vec_len*elem_width-1:0] vec_a,
    input  logic [vec_len*elem_width-1:0] vec_b,
    input  logic [$clog2(vec_len)-1:0]    rd_index,
    output logic                          txd,
    output logic                          done,
    output logic                          busy
);

    result_word_t result;
    logic         op_done;
    logic         register_result;
    logic         send_b0;
    logic         send_b1;
    logic         send_b2;
    logic         send_b3;
    logic         tx_start;
    logic         tx_busy;

    vector_alu #(
        .vec_len (vec_len)
    ) u_alu (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .op       (op),
        .vec_a    (vec_a),
        .vec_b    (vec_b),
        .rd_index (rd_index),
        .done     (done),
        .result   (result),
        .op_done  (op_done),
        .busy     (busy)
    );

    // sequencer runs alongside the alu and drives the byte strobes
    tx_ctrl #(
        .register_wait (register_wait)
    ) u_tx_ctrl (
        .clk             (clk),
        .reset           (reset),
        .op_done         (op_done),
        .tx_busy         (tx_busy),
        .op              (op),
        .register_result (register_result),
        .send_b0         (send_b0),
        .send_b1         (send_b1),
        .send_b2         (send_b2),
        .send_b3         (send_b3),
        .tx_start        (tx_start),
        .done            (done)
    );

    uart_result_tx #(
        .clks_per_bit (clks_per_bit)
    ) u_uart (
        .clk             (clk),
        .reset           (reset),
        .result          (result),
        .register_result (register_result),
        .send_b0         (send_b0),
        .send_b1         (send_b1),
        .send_b2         (send_b2),
        .send_b3         (send_b3),
        .tx_start        (tx_start),
        .txd             (txd),
        .tx_busy         (tx_busy)
    );

endmodule

/* test/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int period = 40
) (
    output logic clk
);

    // free running, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

endmodule

/* test/tb_vec_result.sv */
`timescale 1ns/1ps

module tb_vec_result import vec_pkg::*; ();

    localparam int vec_len       = 4;
    localparam int register_wait = 4;
    localparam int clks_per_bit  = 8;
    localparam int idx_width     = $clog2(vec_len);
    localparam int vec_width     = vec_len * elem_width;
    localparam int wait_limit    = 200;
    localparam int random_count  = 12;

    typedef struct {
        logic [op_width-1:0]  op;
        logic [vec_width-1:0] a;
        logic [vec_width-1:0] b;
        logic [idx_width-1:0] idx;
        int                   nbytes;
        bit                   extra_start;
    } entry_t;

    logic                 clk;
    logic                 reset;
    logic                 start;
    logic [op_width-1:0]  op;
    logic [vec_width-1:0] vec_a;
    logic [vec_width-1:0] vec_b;
    logic [idx_width-1:0] rd_index;
    logic                 txd;
    logic                 done;
    logic                 busy;

    entry_t table_q[$];
    integer seed = 32'he80f6977;

    tb_clock #(
        .period (40)
    ) u_clock (
        .clk (clk)
    );

    vec_result_top #(
        .vec_len       (vec_len),
        .register_wait (register_wait),
        .clks_per_bit  (clks_per_bit)
    ) DUT (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .op       (op),
        .vec_a    (vec_a),
        .vec_b    (vec_b),
        .rd_index (rd_index),
        .txd      (txd),
        .done     (done),
        .busy     (busy)
    );

    task automatic stop_on_error(string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("Fail: %s expected %h got %h", name, expected, actual));
        end
    endtask

    task automatic check_byte_count(string name, int expected, int actual);
        if (actual != expected) begin
            stop_on_error($sformatf("Fail: %s expected %h got %h", name, expected, actual));
        end
    endtask

    task automatic check_result(string name, result_word_t expected, result_word_t actual);
        if (actual.word !== expected.word) begin
            stop_on_error($sformatf("Fail: %s expected %h got %h", name,
                                    expected.word, actual.word));
        end
    endtask

    task automatic wait_cycles(int n);
        int i;
        for (i = 0; i < n; i++) begin
            @(negedge clk);
        end
    endtask

    function automatic logic [op_width-1:0] one_hot(int k);
        logic [op_width-1:0] v;
        v    = '0;
        v[k] = 1'b1;
        return v;
    endfunction

    // 2 bytes for read, sum, avg; 3 for man; 4 for euc and dot
    function automatic int byte_count_for(logic [op_width-1:0] op_v);
        if (op_v[op_man_bit]) begin
            return 3;
        end else if (op_v[op_euc_bit] || op_v[op_dot_bit]) begin
            return 4;
        end
        return 2;
    endfunction

    function automatic logic [vec_width-1:0] random_vector();
        logic [vec_width-1:0] v;
        int i;
        for (i = 0; i < vec_len; i++) begin
            v[i*elem_width +: elem_width] = elem_width'($random(seed));
        end
        return v;
    endfunction

    // expected word straight from the operation definitions
    function automatic result_word_t model_result(entry_t e);
        result_word_t r;
        int unsigned  ea;
        int unsigned  eb;
        int unsigned  diff;
        int unsigned  total;
        int unsigned  abs_sum;
        int unsigned  sq_sum;
        int unsigned  dot_sum;
        int i;
        total   = 0;
        abs_sum = 0;
        sq_sum  = 0;
        dot_sum = 0;
        for (i = 0; i < vec_len; i++) begin
            ea      = 32'(e.a[i*elem_width +: elem_width]);
            eb      = 32'(e.b[i*elem_width +: elem_width]);
            diff    = (ea > eb) ? ea - eb : eb - ea;
            total   = total + ea;
            abs_sum = abs_sum + diff;
            sq_sum  = sq_sum + diff * diff;
            dot_sum = dot_sum + ea * eb;
        end
        r.word = '0;
        case (1'b1)
            e.op[op_read_bit]: r.word = 32'(e.a[32'(e.idx)*elem_width +: elem_width]);
            e.op[op_sum_bit]:  r.word = total;
            e.op[op_avg_bit]:  r.word = total / 32'(vec_len);
            e.op[op_man_bit]:  r.word = abs_sum;
            e.op[op_euc_bit]:  r.word = sq_sum;
            e.op[op_dot_bit]:  r.word = dot_sum;
            default:           r.word = '0;
        endcase
        return r;
    endfunction

    // only the bytes that go out on the line
    function automatic result_word_t keep_bytes(result_word_t w, int n);
        result_word_t r;
        int i;
        r = w;
        for (i = n; i < result_bytes; i++) begin
            r.bytes[i] = 8'h00;
        end
        return r;
    endfunction

    task automatic add_entry(logic [op_width-1:0] op_v, logic [vec_width-1:0] a,
                             logic [vec_width-1:0] b, logic [idx_width-1:0] idx,
                             int nbytes, bit extra);
        entry_t e;
        e.op          = op_v;
        e.a           = a;
        e.b           = b;
        e.idx         = idx;
        e.nbytes      = nbytes;
        e.extra_start = extra;
        table_q.push_back(e);
    endtask

    task automatic load_table();
        logic [op_width-1:0]  op_v;
        logic [vec_width-1:0] a;
        logic [vec_width-1:0] b;
        logic [idx_width-1:0] idx;
        int k;
        int i;
        add_entry(one_hot(op_read_bit), 32'h8040_2010, 32'h0000_0000, idx_width'(2), 2, 1'b0);
        add_entry(one_hot(op_sum_bit),  32'hfffe_fdfc, 32'h1234_5678, idx_width'(0), 2, 1'b0);
        add_entry(one_hot(op_avg_bit),  32'h0a05_0301, 32'h0000_0000, idx_width'(1), 2, 1'b0);
        add_entry(one_hot(op_man_bit),  32'h10ff_0020, 32'hff00_1020, idx_width'(3), 3, 1'b0);
        add_entry(one_hot(op_euc_bit),  32'hffff_ffff, 32'h0000_0000, idx_width'(0), 4, 1'b0);
        add_entry(one_hot(op_dot_bit),  32'hff80_ff01, 32'hff02_ff80, idx_width'(0), 4, 1'b0);
        add_entry(one_hot(op_sum_bit),  32'h0102_0304, 32'h0000_0000, idx_width'(0), 2, 1'b1);
        add_entry(one_hot(op_man_bit),  32'h00ff_00ff, 32'hff00_ff00, idx_width'(1), 3, 1'b1);
        for (i = 0; i < random_count; i++) begin
            k    = $unsigned($random(seed)) % op_width;
            op_v = one_hot(k);
            a    = random_vector();
            b    = random_vector();
            idx  = idx_width'($unsigned($random(seed)) % vec_len);
            add_entry(op_v, a, b, idx, byte_count_for(op_v), (i % 3) == 0);
        end
    endtask

    // called at the first low sample of the start bit
    task automatic receive_byte(output logic [7:0] data);
        int i;
        wait_cycles(clks_per_bit / 2 - 1);
        check_bit("txd start bit", 1'b0, txd);
        for (i = 0; i < 8; i++) begin
            wait_cycles(clks_per_bit);
            check_bit("done", 1'b0, done);
            data[i] = txd;
        end
        wait_cycles(clks_per_bit);
        check_bit("txd stop bit", 1'b1, txd);
    endtask

    task automatic run_entry(entry_t e);
        result_word_t got;
        result_word_t expected;
        logic [7:0]   data;
        int           count;
        int           timer;
        bit           poked;
        bit           seen_done;
        got.word  = '0;
        count     = 0;
        timer     = 0;
        poked     = 1'b0;
        seen_done = 1'b0;
        check_bit("busy", 1'b0, busy);
        op       = e.op;
        vec_a    = e.a;
        vec_b    = e.b;
        rd_index = e.idx;
        start    = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_bit("busy", 1'b1, busy);
        while (!seen_done) begin
            start = 1'b0;
            if (done) begin
                seen_done = 1'b1;
            end else if (txd == 1'b0) begin
                if (count >= e.nbytes) begin
                    stop_on_error("a start bit came after the last byte of the result");
                end else begin
                    receive_byte(data);
                    got.bytes[count] = data;
                    count++;
                    timer = 0;
                end
            end else begin
                // second start while the result is still going out
                if (e.extra_start && count == 1 && !poked) begin
                    start = 1'b1;
                    poked = 1'b1;
                end
                timer++;
                if (timer > wait_limit) begin
                    stop_on_error("timeout, neither a start bit nor the done pulse came");
                end else begin
                    @(negedge clk);
                end
            end
        end
        expected = keep_bytes(model_result(e), e.nbytes);
        check_byte_count("byte count", e.nbytes, count);
        check_result("result", expected, got);
        @(negedge clk);
        check_bit("done", 1'b0, done);
        check_bit("busy", 1'b0, busy);
        check_bit("txd", 1'b1, txd);
    endtask

    initial begin
        int i;
        reset    = 1'b1;
        start    = 1'b0;
        op       = '0;
        vec_a    = '0;
        vec_b    = '0;
        rd_index = '0;
        load_table();
        wait_cycles(5);
        reset = 1'b0;
        @(negedge clk);
        check_bit("txd", 1'b1, txd);
        check_bit("done", 1'b0, done);
        check_bit("busy", 1'b0, busy);
        for (i = 0; i < table_q.size(); i++) begin
            run_entry(table_q[i]);
        end
        wait_cycles(2);
        $display("TEST PASSED");
        $finish;
    end

endmodule

/* tb.f */
common/vec_pkg.sv
logic/vector_alu.sv
tx_ctrl/tx_ctrl.sv
uart/uart_result_tx.sv
logic/vec_result_top.sv
test/tb_clock.sv
test/tb_vec_result.sv

/* Makefile */
TOP = tb_vec_result

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary -f tb.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir
